// File: coeff_fifo.sv
`timescale 1ns/1ps
module coeff_fifo #(
  parameter int DATA_W = 64,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                              dram_clk,
  input  logic                              reset,
  input  logic                              wr_en,
  input  logic [DATA_W-1:0]                 din,
  input  logic                              rd_en,
  output logic [2*frame_pkg::DN_W-1:0]      dout,
  output logic [$clog2(FIFO_DEPTH):0]       level,
  output logic                              empty
);
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int LVL_W = PTR_W + 1;
  localparam int ENTRY_W = 2 * frame_pkg::DN_W;

  logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [LVL_W-1:0] count;
  logic full;

  assign level = count;
  assign empty = count == '0;
  assign full = count == LVL_W'(FIFO_DEPTH);
  assign dout = mem[rd_ptr];  // show-ahead, popped entry is valid now

  // only dark0/dark1 are kept, the kind and upper bits are dropped
  always_ff @(posedge dram_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din[ENTRY_W-1:0];
    end
  end

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the read throttle upstream must keep us from ever filling up
  no_overflow: assert property (@(posedge dram_clk) disable iff (reset)
    wr_en |-> !full);

  no_underflow: assert property (@(posedge dram_clk) disable iff (reset)
    rd_en |-> !empty);

endmodule

// File: dram_ifc.sv
`timescale 1ns/1ps
module dram_ifc #(
  parameter int MSG_W = 32,
  parameter int DATA_W = 64,
  parameter int ADDR_W = 27,
  parameter int FIFO_DEPTH = 16,
  parameter int FIFO_HIGH = 12
) (
  input  logic                        dram_clk,
  input  logic                        reset,
  input  logic                        app_rdy,
  output logic                        app_en,
  output logic [2:0]                  app_cmd,
  output logic [ADDR_W-1:0]           app_addr,
  input  logic                        app_wdf_rdy,
  output logic                        app_wdf_wren,
  output logic                        app_wdf_end,
  output logic [DATA_W-1:0]           app_wdf_data,
  input  logic                        app_rd_data_valid,
  input  logic [DATA_W-1:0]           app_rd_data,
  input  logic                        pc_msg_pending,
  input  logic [MSG_W-1:0]            pc_msg,
  output logic                        pc_msg_ack,
  input  logic [$clog2(FIFO_DEPTH):0] fifo_level,
  input  logic                        frame_done,
  output logic                        fifo_wr_en,
  output logic [DATA_W-1:0]           fifo_din,
  output logic                        dn_valid,
  output logic [MSG_W-1:0]            dn_word,
  output logic                        ifc_error
);
  localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;
  localparam int PEND_W = LVL_W + 1;
  localparam logic [ADDR_W-1:0] ADDR_BASE = ADDR_W'(frame_pkg::START_ADDR);
  localparam logic [ADDR_W-1:0] ADDR_STEP = ADDR_W'(frame_pkg::ADDR_INC);

  frame_pkg::dramifc_state_e state;
  frame_pkg::coeff_kind_e msg_kind;
  frame_pkg::coeff_kind_e beat_kind;

  logic [2*DATA_W-1:0] burst;  // four messages, first one at the top
  logic [1:0] msg_cnt;
  logic [ADDR_W-1:0] end_addr;
  logic [ADDR_W-1:0] addr_next;
  logic [LVL_W-1:0] outstanding;  // read beats not yet returned
  logic [PEND_W-1:0] pend;
  logic [PEND_W-1:0] pend_next;
  logic rd_mode;
  logic rd_phase;
  logic take;
  logic wr_acc;
  logic rd_acc;
  logic more;
  logic room;

  assign msg_kind = frame_pkg::coeff_kind_e'(pc_msg[MSG_W-1 -: frame_pkg::KIND_W]);
  assign beat_kind = frame_pkg::coeff_kind_e'(app_rd_data[DATA_W-1 -: frame_pkg::KIND_W]);

  assign rd_phase = (state == frame_pkg::IFC_READING) ||
                    (state == frame_pkg::IFC_THROTTLED) ||
                    (state == frame_pkg::IFC_PIXELS);

  // never take in the ack cycle, the host still shows the old message
  assign take = pc_msg_pending && !pc_msg_ack &&
                (rd_phase || state == frame_pkg::IFC_MSG_WAIT);

  assign app_cmd = {2'b00, rd_mode};  // 0 write, 1 read
  assign wr_acc = app_en && app_rdy && app_wdf_rdy && !rd_mode;
  assign rd_acc = app_en && app_rdy && rd_mode;
  assign addr_next = rd_acc ? app_addr + ADDR_STEP : app_addr;
  assign more = addr_next != end_addr;

  // worst case of fifo plus in-flight beats one cycle ahead, so a read
  // issued on the next app_en still lands at or below the high mark
  assign pend = PEND_W'(fifo_level) + PEND_W'(outstanding);
  assign pend_next = pend + (rd_acc ? PEND_W'(2) : PEND_W'(0));
  assign room = (pend_next + PEND_W'(2)) <= PEND_W'(FIFO_HIGH);

  assign fifo_wr_en = app_rd_data_valid && beat_kind == frame_pkg::KIND_DARK;
  assign fifo_din = app_rd_data;
  assign ifc_error = state == frame_pkg::IFC_ERROR;

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + (rd_acc ? LVL_W'(2) : LVL_W'(0))
                     - LVL_W'(app_rd_data_valid);
    end
  end

  always_ff @(posedge dram_clk) begin
    if (take) begin
      dn_word <= pc_msg;
    end
    if (take && state == frame_pkg::IFC_MSG_WAIT &&
        msg_kind != frame_pkg::KIND_PIXEL_DATA) begin
      burst[(2'd3 - msg_cnt) * MSG_W +: MSG_W] <= pc_msg;
    end
    if (state == frame_pkg::IFC_WR_WAIT && wr_acc) begin
      app_wdf_data <= burst[DATA_W +: DATA_W];  // messages 1 and 2
    end else if (state == frame_pkg::IFC_WR1 && app_wdf_rdy) begin
      app_wdf_data <= burst[0 +: DATA_W];
    end
  end

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      state <= frame_pkg::IFC_MSG_WAIT;
      app_en <= 1'b0;
      rd_mode <= 1'b0;
      app_addr <= ADDR_BASE;
      end_addr <= ADDR_BASE;
      msg_cnt <= '0;
      app_wdf_wren <= 1'b0;
      app_wdf_end <= 1'b1;
      pc_msg_ack <= 1'b0;
      dn_valid <= 1'b0;
    end else begin
      pc_msg_ack <= take;
      dn_valid <= take && rd_phase && msg_kind == frame_pkg::KIND_PIXEL_DATA;

      case (state)
        frame_pkg::IFC_MSG_WAIT: begin
          if (take) begin
            if (msg_kind == frame_pkg::KIND_PIXEL_DATA) begin
              rd_mode <= 1'b1;  // start message, nothing left to write
              app_addr <= ADDR_BASE;
              state <= frame_pkg::IFC_THROTTLED;
            end else begin
              msg_cnt <= msg_cnt + 1'b1;
              if (msg_cnt == 2'd3) begin
                app_addr <= end_addr;
                app_en <= 1'b1;
                state <= frame_pkg::IFC_WR_WAIT;
              end
            end
          end
        end

        frame_pkg::IFC_WR_WAIT: begin
          if (wr_acc) begin
            app_en <= 1'b0;
            end_addr <= end_addr + ADDR_STEP;
            app_wdf_wren <= 1'b1;
            app_wdf_end <= 1'b0;
            state <= frame_pkg::IFC_WR1;
          end
        end

        frame_pkg::IFC_WR1: begin
          if (app_wdf_rdy) begin
            app_wdf_end <= 1'b1;
            state <= frame_pkg::IFC_WR2;
          end
        end

        frame_pkg::IFC_WR2: begin
          app_wdf_wren <= 1'b0;
          state <= app_wdf_rdy ? frame_pkg::IFC_MSG_WAIT : frame_pkg::IFC_ERROR;
        end

        frame_pkg::IFC_ERROR: begin
          app_en <= 1'b0;  // final state
        end

        default: begin
          // read phase, pixels flow alongside the coefficient reads
          if (take && msg_kind != frame_pkg::KIND_PIXEL_DATA) begin
            app_en <= 1'b0;
            state <= frame_pkg::IFC_ERROR;
          end else if (frame_done) begin
            app_en <= 1'b0;
            app_addr <= ADDR_BASE;  // re-read for the next frame
            state <= frame_pkg::IFC_THROTTLED;
          end else if (state == frame_pkg::IFC_READING) begin
            app_addr <= addr_next;
            app_en <= more && room;
            if (!more) begin
              state <= frame_pkg::IFC_PIXELS;
            end else if (!room) begin
              state <= frame_pkg::IFC_THROTTLED;
            end
          end else if (state == frame_pkg::IFC_THROTTLED) begin
            if (!more) begin
              state <= frame_pkg::IFC_PIXELS;
            end else if (room) begin
              app_en <= 1'b1;
              state <= frame_pkg::IFC_READING;
            end
          end
        end
      endcase
    end
  end

  ack_single: assert property (@(posedge dram_clk) disable iff (reset)
    pc_msg_ack |=> !pc_msg_ack);

  // a burst always closes on its last beat
  end_on_drop: assert property (@(posedge dram_clk) disable iff (reset)
    $fell(app_wdf_wren) |-> app_wdf_end);

endmodule

// File: frame_pkg.sv
package frame_pkg;

  // pixel and dark values are 12-bit DN
  parameter int DN_W = 12;

  // kind field sits at the top of every host message and DRAM beat
  parameter int KIND_W = 2;

  // row counter and row tag in the output message
  parameter int ROW_W = 8;

  // DRAM layout of the coefficient region
  parameter int START_ADDR = 0;
  parameter int ADDR_INC = 8;  // BL8, one burst per step

  typedef enum logic [KIND_W-1:0] {
    KIND_PIXEL_DATA = 2'd0,  // pixel message, or start of pixel phase
    KIND_DARK       = 2'd1,
    KIND_ROW        = 2'd2,
    KIND_PATCH      = 2'd3
  } coeff_kind_e;

  typedef enum logic [2:0] {
    IFC_MSG_WAIT,
    IFC_WR_WAIT,
    IFC_WR1,
    IFC_WR2,
    IFC_READING,
    IFC_THROTTLED,
    IFC_PIXELS,
    IFC_ERROR
  } dramifc_state_e;

  typedef enum logic [2:0] {
    CAP_STANDBY,
    CAP_INTRALINE,
    CAP_INTERLINE,
    CAP_INTERFRAME,
    CAP_ERROR
  } capture_state_e;

endpackage

// File: frame_top.sv
`timescale 1ns/1ps
module frame_top #(
  parameter int MSG_W = 32,
  parameter int DATA_W = 64,
  parameter int ADDR_W = 27,
  parameter int FIFO_DEPTH = 16,
  parameter int FIFO_HIGH = 12
) (
  input  logic               reset,
  input  logic               dram_clk,
  input  logic               app_rdy,
  input  logic               app_wdf_rdy,
  input  logic               app_rd_data_valid,
  input  logic [DATA_W-1:0]  app_rd_data,
  output logic               app_en,
  output logic               app_wdf_wren,
  output logic               app_wdf_end,
  output logic [2:0]         app_cmd,
  output logic [ADDR_W-1:0]  app_addr,
  output logic [DATA_W-1:0]  app_wdf_data,
  input  logic               pc_msg_pending,
  input  logic [MSG_W-1:0]   pc_msg,
  output logic               pc_msg_ack,
  output logic               fpga_msg_valid,
  output logic [MSG_W-1:0]   fpga_msg,
  output logic               error
);
  logic fifo_wr_en;
  logic fifo_rd_en;
  logic fifo_empty;
  logic [DATA_W-1:0] fifo_din;
  logic [2*frame_pkg::DN_W-1:0] fifo_dout;
  logic [$clog2(FIFO_DEPTH):0] fifo_level;
  logic frame_done;
  logic dn_valid;
  logic [MSG_W-1:0] dn_word;
  logic ifc_error;
  logic cap_error;

  dram_ifc #(
    .MSG_W(MSG_W),
    .DATA_W(DATA_W),
    .ADDR_W(ADDR_W),
    .FIFO_DEPTH(FIFO_DEPTH),
    .FIFO_HIGH(FIFO_HIGH)
  ) i_dram_ifc (
    .dram_clk(dram_clk),
    .reset(reset),
    .app_rdy(app_rdy),
    .app_en(app_en),
    .app_cmd(app_cmd),
    .app_addr(app_addr),
    .app_wdf_rdy(app_wdf_rdy),
    .app_wdf_wren(app_wdf_wren),
    .app_wdf_end(app_wdf_end),
    .app_wdf_data(app_wdf_data),
    .app_rd_data_valid(app_rd_data_valid),
    .app_rd_data(app_rd_data),
    .pc_msg_pending(pc_msg_pending),
    .pc_msg(pc_msg),
    .pc_msg_ack(pc_msg_ack),
    .fifo_level(fifo_level),
    .frame_done(frame_done),
    .fifo_wr_en(fifo_wr_en),
    .fifo_din(fifo_din),
    .dn_valid(dn_valid),
    .dn_word(dn_word),
    .ifc_error(ifc_error)
  );

  coeff_fifo #(
    .DATA_W(DATA_W),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_coeff_fifo (
    .dram_clk(dram_clk),
    .reset(reset),
    .wr_en(fifo_wr_en),
    .din(fifo_din),
    .rd_en(fifo_rd_en),
    .dout(fifo_dout),
    .level(fifo_level),
    .empty(fifo_empty)
  );

  pixel_capture #(
    .MSG_W(MSG_W)
  ) i_pixel_capture (
    .dram_clk(dram_clk),
    .reset(reset),
    .dn_valid(dn_valid),
    .dn_word(dn_word),
    .fifo_dout(fifo_dout),
    .fifo_empty(fifo_empty),
    .fifo_rd_en(fifo_rd_en),
    .frame_done(frame_done),
    .fpga_msg_valid(fpga_msg_valid),
    .fpga_msg(fpga_msg),
    .cap_error(cap_error)
  );

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      error <= 1'b0;
    end else if (ifc_error || cap_error) begin
      error <= 1'b1;  // sticky until reset
    end
  end

endmodule

// File: pixel_capture.sv
`timescale 1ns/1ps
module pixel_capture #(
  parameter int MSG_W = 32
) (
  input  logic                          dram_clk,
  input  logic                          reset,
  input  logic                          dn_valid,
  input  logic [MSG_W-1:0]              dn_word,
  input  logic [2*frame_pkg::DN_W-1:0]  fifo_dout,
  input  logic                          fifo_empty,
  output logic                          fifo_rd_en,
  output logic                          frame_done,
  output logic                          fpga_msg_valid,
  output logic [MSG_W-1:0]              fpga_msg,
  output logic                          cap_error
);
  localparam int DN_W = frame_pkg::DN_W;
  localparam int ROW_W = frame_pkg::ROW_W;

  frame_pkg::capture_state_e state;

  logic [DN_W-1:0] dn0;
  logic [DN_W-1:0] dn1;
  logic [DN_W-1:0] dark0;
  logic [DN_W-1:0] dark1;
  logic fval;
  logic lval;
  logic [ROW_W-1:0] row;
  logic [ROW_W-1:0] row_now;
  logic take_px;

  // subtract stage, one extra bit holds the borrow
  logic s1_valid;
  logic [ROW_W-1:0] s1_row;
  logic [DN_W:0] s1_diff0;
  logic [DN_W:0] s1_diff1;

  assign {dn0, fval, lval, dn1} = dn_word[2*DN_W+1:0];
  assign {dark0, dark1} = fifo_dout;

  // first line of a new frame is row 0 before the counter clears
  assign row_now = (state == frame_pkg::CAP_INTERFRAME) ? '0 : row;

  assign take_px = dn_valid && lval && !fifo_empty &&
                   state != frame_pkg::CAP_ERROR;
  assign fifo_rd_en = take_px;  // one dark pair per pixel pair
  assign cap_error = state == frame_pkg::CAP_ERROR;

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      state <= frame_pkg::CAP_STANDBY;
      row <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (dn_valid && state != frame_pkg::CAP_ERROR) begin
        if (lval && fifo_empty) begin
          state <= frame_pkg::CAP_ERROR;  // coefficients did not arrive in time
        end else begin
          case (state)
            frame_pkg::CAP_STANDBY: begin
              if (fval) begin
                state <= frame_pkg::CAP_INTRALINE;
              end
            end
            frame_pkg::CAP_INTRALINE: begin
              if (!lval && fval) begin
                row <= row + 1'b1;
                state <= frame_pkg::CAP_INTERLINE;
              end else if (!lval) begin
                frame_done <= 1'b1;
                state <= frame_pkg::CAP_INTERFRAME;
              end
            end
            frame_pkg::CAP_INTERLINE: begin
              if (lval) begin
                state <= frame_pkg::CAP_INTRALINE;
              end else if (!fval) begin
                frame_done <= 1'b1;
                state <= frame_pkg::CAP_INTERFRAME;
              end
            end
            frame_pkg::CAP_INTERFRAME: begin
              if (lval) begin
                row <= '0;
                state <= frame_pkg::CAP_INTRALINE;
              end
            end
            default: state <= frame_pkg::CAP_ERROR;
          endcase
        end
      end
    end
  end

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      fpga_msg_valid <= 1'b0;
    end else begin
      s1_valid <= take_px;
      fpga_msg_valid <= s1_valid;
    end
  end

  always_ff @(posedge dram_clk) begin
    if (take_px) begin
      s1_row <= row_now;
      s1_diff0 <= {1'b0, dn0} - {1'b0, dark0};
      s1_diff1 <= {1'b0, dn1} - {1'b0, dark1};
    end
    if (s1_valid) begin
      // negative results clamp to zero
      fpga_msg <= MSG_W'({s1_row,
                          s1_diff0[DN_W] ? {DN_W{1'b0}} : s1_diff0[DN_W-1:0],
                          s1_diff1[DN_W] ? {DN_W{1'b0}} : s1_diff1[DN_W-1:0]});
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
rm -f sim.log
{ verilator --binary --timing --assert -f verilog.f --top-module tb_frame_top \
    -o tb_frame_top > sim.log 2>&1 && ./obj_dir/tb_frame_top >> sim.log 2>&1; } \
  || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

// File: tb_dram_model.sv
`timescale 1ns/1ps
module tb_dram_model #(
  parameter int DATA_W = 64,
  parameter int ADDR_W = 27,
  parameter int RD_LAT = 6,
  parameter int N_BEATS = 64
) (
  input  logic              dram_clk,
  input  logic              reset,
  input  logic              app_en,
  input  logic [2:0]        app_cmd,
  input  logic [ADDR_W-1:0] app_addr,
  input  logic              app_wdf_wren,
  input  logic              app_wdf_end,
  input  logic [DATA_W-1:0] app_wdf_data,
  output logic              app_rdy,
  output logic              app_wdf_rdy,
  output logic              app_rd_data_valid,
  output logic [DATA_W-1:0] app_rd_data
);
  logic [DATA_W-1:0] mem [N_BEATS];
  int cycle;
  int wr_bursts;    // accepted write commands
  int wr_beat;      // 0 or 1 within the current burst
  int rd_next;      // next address a read must use
  int outstanding;  // read beats accepted and not yet presented
  int dark_returned;
  int rq_due[$];
  int rq_idx[$];
  logic err;
  string err_msg;

  initial begin
    app_rdy = 1'b0;
    app_wdf_rdy = 1'b0;
    app_rd_data_valid = 1'b0;
    app_rd_data = '0;
    err = 1'b0;
  end

  always @(posedge dram_clk) begin
    if (reset) begin
      cycle = 0;
      wr_bursts = 0;
      wr_beat = 0;
      rd_next = 0;
      outstanding = 0;
      dark_returned = 0;
      rq_due.delete();
      rq_idx.delete();
    end else begin
      cycle++;
      if (app_en && app_rdy && app_cmd == 3'd0 && app_wdf_rdy) begin
        if (int'(app_addr) != wr_bursts * 8) begin
          err_msg = $sformatf("CHECK FAILED app_addr write: got %h expected %h",
                              app_addr, wr_bursts * 8);
          err = 1'b1;
        end
        wr_bursts++;
      end
      if (app_wdf_wren && app_wdf_rdy) begin
        if (app_wdf_end != (wr_beat == 1)) begin
          err_msg = $sformatf("CHECK FAILED app_wdf_end: got %h on beat %h",
                              app_wdf_end, wr_beat);
          err = 1'b1;
        end
        mem[(wr_bursts - 1) * 2 + wr_beat] = app_wdf_data;
        wr_beat ^= 1;
      end
      if (app_en && app_rdy && app_cmd == 3'd1) begin
        if (int'(app_addr) != rd_next || rd_next >= wr_bursts * 8) begin
          err_msg = $sformatf("CHECK FAILED app_addr read: got %h expected %h",
                              app_addr, rd_next);
          err = 1'b1;
        end
        rq_due.push_back(cycle + RD_LAT);
        rq_idx.push_back(rd_next / 4);
        rq_due.push_back(cycle + RD_LAT);
        rq_idx.push_back(rd_next / 4 + 1);
        outstanding += 2;
        rd_next += 8;
        if (rd_next == wr_bursts * 8) rd_next = 0;  // next frame starts over
      end
    end
  end

  // outputs change a little after the edge, second write beat is never stalled
  always @(posedge dram_clk) begin
    #1;
    app_rdy = ($urandom % 4) != 0;
    app_wdf_rdy = (app_wdf_wren && app_wdf_end) ? 1'b1 : (($urandom % 4) != 0);
    app_rd_data_valid = 1'b0;
    if (!reset && rq_due.size() > 0 && rq_due[0] <= cycle) begin
      app_rd_data = mem[rq_idx[0]];
      app_rd_data_valid = 1'b1;
      void'(rq_due.pop_front());
      void'(rq_idx.pop_front());
      outstanding--;
      if (app_rd_data[DATA_W-1 -: 2] == 2'd1) dark_returned++;
    end
  end

endmodule

// File: tb_frame_top.sv
`timescale 1ns/1ps
module tb_frame_top;
  localparam int MSG_W = 32;
  localparam int DATA_W = 64;
  localparam int ADDR_W = 27;
  localparam int FIFO_HIGH = 12;
  localparam int N_BEATS = 28;  // 24 dark beats and 4 row beats

  logic dram_clk;
  logic reset;
  logic app_rdy, app_wdf_rdy, app_rd_data_valid;
  logic [DATA_W-1:0] app_rd_data;
  logic app_en, app_wdf_wren, app_wdf_end;
  logic [2:0] app_cmd;
  logic [ADDR_W-1:0] app_addr;
  logic [DATA_W-1:0] app_wdf_data;
  logic pc_msg_pending;
  logic [MSG_W-1:0] pc_msg;
  logic pc_msg_ack;
  logic fpga_msg_valid;
  logic [MSG_W-1:0] fpga_msg;
  logic error;

  logic [DATA_W-1:0] beats [N_BEATS];
  logic [23:0] darks [24];
  logic [MSG_W-1:0] exp_q[$];
  int lval_sent;
  int pops;
  logic expect_err;

  frame_top #(
    .MSG_W(MSG_W), .DATA_W(DATA_W), .ADDR_W(ADDR_W), .FIFO_DEPTH(16), .FIFO_HIGH(FIFO_HIGH)
  ) i_frame_top (
    .reset(reset), .dram_clk(dram_clk), .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
    .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data), .app_en(app_en),
    .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end), .app_cmd(app_cmd),
    .app_addr(app_addr), .app_wdf_data(app_wdf_data), .pc_msg_pending(pc_msg_pending),
    .pc_msg(pc_msg), .pc_msg_ack(pc_msg_ack), .fpga_msg_valid(fpga_msg_valid),
    .fpga_msg(fpga_msg), .error(error)
  );

  tb_dram_model #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) i_dram_model (
    .dram_clk(dram_clk), .reset(reset), .app_en(app_en), .app_cmd(app_cmd),
    .app_addr(app_addr), .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end),
    .app_wdf_data(app_wdf_data), .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
    .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data)
  );

  initial begin
    dram_clk = 1'b0;
    forever #4 dram_clk = ~dram_clk;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  function automatic logic [11:0] sub_clamp(input logic [11:0] dn, input logic [11:0] dark);
    return (dn > dark) ? dn - dark : 12'd0;
  endfunction

  task automatic send_msg(input logic [MSG_W-1:0] m);
    int n;
    n = 0;
    pc_msg = m;
    pc_msg_pending = 1'b1;
    do begin
      @(posedge dram_clk);
      #1;
      n++;
      if (n > 500) fail_now("timeout waiting for pc_msg_ack");
    end while (!pc_msg_ack);
    pc_msg_pending = 1'b0;
  endtask

  // lval pixels go out only once a dark beat is back for them
  task automatic send_pixel(input logic fval, input logic lval, input int row, input int idx);
    logic [11:0] dn0, dn1;
    int n;
    dn0 = 12'($urandom);
    dn1 = 12'($urandom);
    n = 0;
    if (lval) begin
      while (i_dram_model.dark_returned <= lval_sent) begin
        @(posedge dram_clk);
        #1;
        n++;
        if (n > 500) fail_now("timeout waiting for dark coefficients");
      end
      exp_q.push_back({8'(row), sub_clamp(dn0, darks[idx][23:12]),
                       sub_clamp(dn1, darks[idx][11:0])});
      lval_sent++;
    end
    send_msg({6'b0, dn0, fval, lval, dn1});
  endtask

  task automatic run_frame();
    for (int line = 0; line < 4; line++) begin
      for (int p = 0; p < 6; p++) send_pixel(1'b1, 1'b1, line, line * 6 + p);
      send_pixel(line < 3, 1'b0, line, 0);  // line end, last one ends the frame
    end
  endtask

  // model checks, throttle bound and output scoreboard
  always @(negedge dram_clk) begin
    if (!reset) begin
      if (i_dram_model.err) fail_now(i_dram_model.err_msg);
      if (i_frame_top.fifo_rd_en) pops++;
      assert (i_dram_model.outstanding + i_dram_model.dark_returned - pops <= FIFO_HIGH)
        else fail_now($sformatf("CHECK FAILED pending beats: got %h limit %h",
          i_dram_model.outstanding + i_dram_model.dark_returned - pops, FIFO_HIGH));
      if (fpga_msg_valid) begin
        if (exp_q.size() == 0) fail_now("fpga_msg_valid with no pixel expected");
        assert (fpga_msg == exp_q[0])
          else fail_now($sformatf("CHECK FAILED fpga_msg: got %h expected %h",
                                  fpga_msg, exp_q[0]));
        void'(exp_q.pop_front());
      end
    end
  end

  no_early_error: assert property (@(posedge dram_clk) disable iff (reset)
    !expect_err |-> !error)
    else fail_now($sformatf("CHECK FAILED error: got %h expected %h", error, 1'b0));

  error_sticky: assert property (@(posedge dram_clk) disable iff (reset)
    error |=> error)
    else fail_now("error dropped after it was raised");

  initial begin
    int n;
    int d;
    reset = 1'b1;
    pc_msg_pending = 1'b0;
    pc_msg = '0;
    expect_err = 1'b0;
    lval_sent = 0;
    pops = 0;
    void'($urandom(44));
    d = 0;
    for (int b = 0; b < N_BEATS; b++) begin
      if (b % 7 == 3) begin
        beats[b] = {2'd2, 30'($urandom), 2'd2, 30'($urandom)};
      end else begin
        darks[d] = 24'($urandom);
        beats[b] = {2'd1, 30'($urandom), 2'd1, 6'($urandom), darks[d]};
        d++;
      end
    end
    repeat (8) @(posedge dram_clk);
    #1;
    assert (!app_en && !app_wdf_wren && !pc_msg_ack && !fpga_msg_valid && !error &&
            app_wdf_end)
      else fail_now($sformatf("CHECK FAILED reset outputs: en %h wren %h ack %h end %h",
                              app_en, app_wdf_wren, pc_msg_ack, app_wdf_end));
    reset = 1'b0;

    for (int b = 0; b < N_BEATS; b++) begin
      send_msg(beats[b][63:32]);
      send_msg(beats[b][31:0]);
    end
    send_msg('0);  // start of pixel phase
    for (int b = 0; b < N_BEATS; b++) begin
      assert (i_dram_model.mem[b] == beats[b])
        else fail_now($sformatf("CHECK FAILED app_wdf_data beat %0d: got %h expected %h",
                                b, i_dram_model.mem[b], beats[b]));
    end

    run_frame();
    run_frame();

    // third frame pixel before any coefficient is back
    expect_err = 1'b1;
    send_msg({6'b0, 12'h123, 1'b1, 1'b1, 12'h456});
    n = 0;
    while (!error) begin
      @(posedge dram_clk);
      #1;
      n++;
      if (n > 50) fail_now("timeout waiting for error");
    end
    repeat (10) @(posedge dram_clk);
    #1;
    if (exp_q.size() != 0 || !error) begin
      fail_now($sformatf("CHECK FAILED outputs left: got %h expected %h", exp_q.size(), 0));
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: verilog.f
frame_pkg.sv
coeff_fifo.sv
dram_ifc.sv
pixel_capture.sv
frame_top.sv
tb_dram_model.sv
tb_frame_top.sv
